/* Bender.yml */
package:
  name: dma_copy

sources:
  # rtl in compile order
  - source/dma_copy_pkg.sv
  - source/dma_csr.sv
  - source/dma_read_engine.sv
  - source/pipe_bridge.sv
  - source/dma_write_engine.sv
  - source/dma_copy_top.sv

  # testbench
  - target: test
    files:
      - verification/dma_copy_tb.sv

/* dma_copy.f */
source/dma_copy_pkg.sv
source/dma_csr.sv
source/dma_read_engine.sv
source/pipe_bridge.sv
source/dma_write_engine.sv
source/dma_copy_top.sv
verification/dma_copy_tb.sv

/* source/dma_copy_pkg.sv */
// ************************************************
// dma copy package: widths, credit counts, register map
// and the request and response structs of all ports
// ************************************************
package dma_copy_pkg;

   // ************************************************
   // sizes
   // ************************************************
   localparam int LINE_W      = 64;  // bits per data line
   localparam int ADDR_W      = 32;  // line address
   localparam int LEN_W       = 16;  // line count
   localparam int MMIO_ADDR_W = 4;   // register offset
   localparam int MMIO_DATA_W = 64;  // register width

   localparam int RD_CREDITS  = 4;   // host reads in flight, same as bridge fifo
   localparam int WR_CREDITS  = 4;   // memory writes granted after reset
   localparam int PIPE_DEPTH  = 2;   // bridge latency in cycles

   localparam int BRIDGE_STAGES = PIPE_DEPTH - 1;           // fifo write is the last stage
   localparam int RD_CRED_W     = $clog2(RD_CREDITS + 1);   // 0..RD_CREDITS
   localparam int WR_CRED_W     = $clog2(WR_CREDITS + 1);   // 0..WR_CREDITS
   localparam int FIFO_PTR_W    = $clog2(RD_CREDITS);       // depth is a power of two

   // ************************************************
   // register map
   // ************************************************
   localparam logic [MMIO_ADDR_W-1:0] REG_SRC    = 4'd0;  // source line address
   localparam logic [MMIO_ADDR_W-1:0] REG_DST    = 4'd1;  // destination line address
   localparam logic [MMIO_ADDR_W-1:0] REG_LEN    = 4'd2;  // line count
   localparam logic [MMIO_ADDR_W-1:0] REG_CTRL   = 4'd3;  // start, irq enable
   localparam logic [MMIO_ADDR_W-1:0] REG_STATUS = 4'd4;  // busy, done, progress

   localparam int CTRL_START  = 0;   // write 1 to kick off
   localparam int CTRL_IRQ_EN = 1;
   localparam int STAT_BUSY   = 0;
   localparam int STAT_DONE   = 1;
   localparam int STAT_LINES  = 16;  // lines_written lsb

   // ************************************************
   // port types
   // ************************************************
   typedef logic [LINE_W-1:0] line_t;

   typedef struct packed {
      logic                   write;
      logic                   read;
      logic [MMIO_ADDR_W-1:0] address;
      logic [MMIO_DATA_W-1:0] writedata;
   } mmio_req_t;

   typedef struct packed {
      logic                   readdatavalid;
      logic [MMIO_DATA_W-1:0] readdata;
   } mmio_rsp_t;

   typedef struct packed {
      logic [ADDR_W-1:0] src;
      logic [ADDR_W-1:0] dst;
      logic [LEN_W-1:0]  len;
   } desc_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] address;
   } rd_req_t;

   typedef struct packed {
      logic  valid;
      line_t data;
   } rd_rsp_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] address;
      line_t             data;
   } wr_req_t;

endpackage

/* source/dma_copy_top.sv */
// ************************************************
// dma copy top: csr, read engine, bridge, write engine
// ************************************************
`timescale 1ns/100ps

module dma_copy_top (
   input  logic                    clk,
   input  logic                    reset,
   input  dma_copy_pkg::mmio_req_t mmio_req,
   output dma_copy_pkg::mmio_rsp_t mmio_rsp,
   output dma_copy_pkg::rd_req_t   rd_req,
   input  dma_copy_pkg::rd_rsp_t   rd_rsp,
   output dma_copy_pkg::wr_req_t   wr_req,
   input  logic                    wr_credit,
   output logic                    irq
);
   import dma_copy_pkg::*;

   desc_t            desc;           // csr -> both engines
   logic             start;
   logic             xfer_done;      // write engine -> csr
   logic [LEN_W-1:0] lines_written;
   logic             credit_return;  // bridge -> read engine
   logic             out_valid;
   line_t            out_data;
   logic             out_ready;

   // ************************************************
   // input side
   // ************************************************
   dma_csr u_dma_csr (
      .clk           (clk),
      .reset         (reset),
      .mmio_req      (mmio_req),
      .mmio_rsp      (mmio_rsp),
      .desc          (desc),
      .start         (start),
      .xfer_done     (xfer_done),
      .lines_written (lines_written),
      .irq           (irq)
   );

   dma_read_engine u_dma_read_engine (
      .clk           (clk),
      .reset         (reset),
      .desc          (desc),
      .start         (start),
      .rd_req        (rd_req),
      .credit_return (credit_return)
   );

   // host return data into the bridge
   pipe_bridge #(
      .payload_t (line_t)
   ) u_pipe_bridge (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (rd_rsp.valid),
      .in_data       (rd_rsp.data),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_ready     (out_ready),
      .credit_return (credit_return)
   );

   // ************************************************
   // output side
   // ************************************************
   dma_write_engine u_dma_write_engine (
      .clk           (clk),
      .reset         (reset),
      .desc          (desc),
      .start         (start),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .out_ready     (out_ready),
      .wr_req        (wr_req),
      .wr_credit     (wr_credit),
      .lines_written (lines_written),
      .xfer_done     (xfer_done)
   );

endmodule

/* source/dma_csr.sv */
// ************************************************
// dma csr: mmio register file with descriptor, control,
// status and interrupt
// ************************************************
`timescale 1ns/100ps

module dma_csr (
   input  logic                           clk,
   input  logic                           reset,
   input  dma_copy_pkg::mmio_req_t        mmio_req,
   output dma_copy_pkg::mmio_rsp_t        mmio_rsp,
   output dma_copy_pkg::desc_t            desc,
   output logic                           start,
   input  logic                           xfer_done,
   input  logic [dma_copy_pkg::LEN_W-1:0] lines_written,
   output logic                           irq
);
   import dma_copy_pkg::*;

   desc_t                  desc_q;       // programmed transfer
   logic                   irq_en_q;
   logic                   busy_q;
   logic                   done_q;
   logic                   start_q;      // one cycle kick to engines
   logic                   rsp_valid_q;
   logic [MMIO_DATA_W-1:0] rsp_data_q;
   logic [MMIO_DATA_W-1:0] status_word;
   logic [MMIO_DATA_W-1:0] rd_mux;
   logic                   ctrl_wr;
   logic                   go;           // accepted start request

   assign ctrl_wr = mmio_req.write && (mmio_req.address == REG_CTRL);
   assign go      = ctrl_wr && mmio_req.writedata[CTRL_START] && !busy_q;  // busy drops it

   always_comb
   begin
      status_word                      = '0;
      status_word[STAT_BUSY]           = busy_q;
      status_word[STAT_DONE]           = done_q;
      status_word[STAT_LINES +: LEN_W] = lines_written;  // live progress
   end

   // read data select
   always_comb
   begin
      rd_mux = '0;
      case (mmio_req.address)
         REG_SRC:    rd_mux[ADDR_W-1:0]  = desc_q.src;
         REG_DST:    rd_mux[ADDR_W-1:0]  = desc_q.dst;
         REG_LEN:    rd_mux[LEN_W-1:0]   = desc_q.len;
         REG_CTRL:   rd_mux[CTRL_IRQ_EN] = irq_en_q;  // start reads back as 0
         REG_STATUS: rd_mux              = status_word;
         default:    rd_mux              = '0;
      endcase
   end

   // ************************************************
   // register writes and transfer state
   // ************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         desc_q      <= '0;
         irq_en_q    <= 1'b0;
         busy_q      <= 1'b0;
         done_q      <= 1'b0;
         start_q     <= 1'b0;
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         start_q     <= go && (desc_q.len != '0);  // empty copy never reaches engines
         rsp_valid_q <= mmio_req.read;              // fixed 1 cycle answer
         if (mmio_req.write)
         begin
            case (mmio_req.address)
               REG_SRC:    desc_q.src <= mmio_req.writedata[ADDR_W-1:0];
               REG_DST:    desc_q.dst <= mmio_req.writedata[ADDR_W-1:0];
               REG_LEN:    desc_q.len <= mmio_req.writedata[LEN_W-1:0];
               REG_CTRL:   irq_en_q   <= mmio_req.writedata[CTRL_IRQ_EN];
               REG_STATUS: done_q     <= 1'b0;  // any write acks done
               default:    ;
            endcase
         end
         if (go)
         begin
            busy_q <= (desc_q.len != '0);
            done_q <= (desc_q.len == '0);  // zero length finishes at once
         end
         else if (xfer_done)
         begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (mmio_req.read)
         rsp_data_q <= rd_mux;
   end

   assign mmio_rsp = '{readdatavalid: rsp_valid_q, readdata: rsp_data_q};
   assign desc     = desc_q;
   assign start    = start_q;
   assign irq      = done_q && irq_en_q;

   // engines see a start only when the previous copy has retired
   a_start_idle : assert property (@(posedge clk) disable iff (reset)
      start |-> $past(!busy_q))
      else $error("start issued during a running transfer");

endmodule

/* source/dma_read_engine.sv */
// ************************************************
// dma read engine: host line reads from the descriptor,
// paced by read credits
// ************************************************
`timescale 1ns/100ps

module dma_read_engine (
   input  logic                  clk,
   input  logic                  reset,
   input  dma_copy_pkg::desc_t   desc,
   input  logic                  start,
   output dma_copy_pkg::rd_req_t rd_req,
   input  logic                  credit_return
);
   import dma_copy_pkg::*;

   logic [ADDR_W-1:0]    addr_q;     // next source line
   logic [LEN_W-1:0]     remain_q;   // lines still to request
   logic [RD_CRED_W-1:0] credits_q;  // free bridge slots
   logic                 issue;

   assign issue  = (remain_q != '0) && (credits_q != '0);
   assign rd_req = '{valid: issue, address: addr_q};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         remain_q  <= '0;
         credits_q <= RD_CRED_W'(RD_CREDITS);  // full bridge budget
      end
      else
      begin
         credits_q <= credits_q - RD_CRED_W'(issue) + RD_CRED_W'(credit_return);
         if (start)
            remain_q <= desc.len;
         else if (issue)
            remain_q <= remain_q - 1'b1;
      end
   end

   // source address walk
   always_ff @(posedge clk)
   begin
      if (start)
         addr_q <= desc.src;
      else if (issue)
         addr_q <= addr_q + 1'b1;
   end

   // bridge returns at most one credit per line it was sent
   a_rd_credit : assert property (@(posedge clk) disable iff (reset)
      (credits_q <= RD_CRED_W'(RD_CREDITS)) && !(rd_req.valid && (credits_q == '0)))
      else $error("read credit count out of range");

endmodule

/* source/dma_write_engine.sv */
// ************************************************
// dma write engine: memory bank writes paced by write
// credits, counts lines to completion
// ************************************************
`timescale 1ns/100ps

module dma_write_engine (
   input  logic                           clk,
   input  logic                           reset,
   input  dma_copy_pkg::desc_t            desc,
   input  logic                           start,
   input  logic                           out_valid,
   input  dma_copy_pkg::line_t            out_data,
   output logic                           out_ready,
   output dma_copy_pkg::wr_req_t          wr_req,
   input  logic                           wr_credit,
   output logic [dma_copy_pkg::LEN_W-1:0] lines_written,
   output logic                           xfer_done
);
   import dma_copy_pkg::*;

   logic [ADDR_W-1:0]    addr_q;     // next destination line
   logic [LEN_W-1:0]     len_q;
   logic [LEN_W-1:0]     count_q;    // lines taken so far
   logic [WR_CRED_W-1:0] credits_q;
   logic                 active_q;
   logic                 done_q;
   logic                 take;       // line moves bridge -> memory
   logic                 last;
   logic                 wr_valid_q;
   logic [ADDR_W-1:0]    wr_addr_q;
   line_t                wr_data_q;

   assign out_ready = active_q && (credits_q != '0);
   assign take      = out_valid && out_ready;
   assign last      = take && ((count_q + 1'b1) == len_q);

   // ************************************************
   // control
   // ************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         active_q   <= 1'b0;
         count_q    <= '0;
         credits_q  <= WR_CRED_W'(WR_CREDITS);
         wr_valid_q <= 1'b0;
         done_q     <= 1'b0;
      end
      else
      begin
         credits_q  <= credits_q - WR_CRED_W'(take) + WR_CRED_W'(wr_credit);
         wr_valid_q <= take;
         done_q     <= last;  // lines up with the final write
         if (start)
         begin
            active_q <= 1'b1;
            count_q  <= '0;
         end
         else if (take)
         begin
            count_q <= count_q + 1'b1;
            if (last)
               active_q <= 1'b0;
         end
      end
   end

   // descriptor capture and write payload
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         len_q  <= desc.len;
         addr_q <= desc.dst;
      end
      else if (take)
         addr_q <= addr_q + 1'b1;
      if (take)
      begin
         wr_addr_q <= addr_q;
         wr_data_q <= out_data;
      end
   end

   assign wr_req        = '{valid: wr_valid_q, address: wr_addr_q, data: wr_data_q};
   assign lines_written = count_q;
   assign xfer_done     = done_q;

   // an underflow wraps above the limit, an extra memory credit too
   a_wr_credit : assert property (@(posedge clk) disable iff (reset)
      credits_q <= WR_CRED_W'(WR_CREDITS))
      else $error("write credit counter out of range");

endmodule

/* source/pipe_bridge.sv */
// ************************************************
// pipe bridge: register pipeline into a credit fifo,
// for any payload type
// ************************************************
`timescale 1ns/100ps

module pipe_bridge #(
   parameter type payload_t = dma_copy_pkg::line_t
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready,
   output logic     credit_return
);
   import dma_copy_pkg::*;

   logic [BRIDGE_STAGES-1:0] stg_v;                // stage valids
   payload_t                 stg_d [BRIDGE_STAGES];
   payload_t                 fifo_mem [RD_CREDITS];
   logic [FIFO_PTR_W-1:0]    wr_ptr_q;
   logic [FIFO_PTR_W-1:0]    rd_ptr_q;
   logic [RD_CRED_W-1:0]     count_q;              // fifo fill
   logic                     push;
   logic                     pop;

   assign push          = stg_v[BRIDGE_STAGES-1];  // pipeline exit
   assign pop           = out_valid && out_ready;
   assign out_valid     = (count_q != '0);
   assign out_data      = fifo_mem[rd_ptr_q];
   assign credit_return = pop;                     // slot freed, one more read allowed

   // ************************************************
   // control: valid chain and fifo pointers
   // ************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         stg_v    <= '0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         stg_v[0] <= in_valid;
         for (int i = 1; i < BRIDGE_STAGES; i++)
            stg_v[i] <= stg_v[i-1];
         if (push)
            wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
         if (pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_q + RD_CRED_W'(push) - RD_CRED_W'(pop);
      end
   end

   // payload path
   always_ff @(posedge clk)
   begin
      stg_d[0] <= in_data;
      for (int i = 1; i < BRIDGE_STAGES; i++)
         stg_d[i] <= stg_d[i-1];
      if (push)
         fifo_mem[wr_ptr_q] <= stg_d[BRIDGE_STAGES-1];
   end

   // holds only while the requester spends credits correctly
   a_no_overflow : assert property (@(posedge clk) disable iff (reset)
      (push && !pop) |-> (count_q < RD_CRED_W'(RD_CREDITS)))
      else $error("bridge fifo overflow");

endmodule

/* verification/dma_copy_tb.sv */
// **************************************************
// dma copy testbench: mmio driver, host and memory
// models, reference data and on-the-fly write checks
// **************************************************
`timescale 1ns/100ps

module dma_copy_tb;
   import dma_copy_pkg::*;

   logic                    clk = 1'b0;
   logic                    reset;
   mmio_req_t               mmio_req;
   mmio_rsp_t               mmio_rsp;
   rd_req_t                 rd_req;
   rd_rsp_t                 rd_rsp = '0;       // host model output
   wr_req_t                 wr_req;
   logic                    wr_credit = 1'b0;  // memory model output
   logic                    irq;

   int                      cycle = 0;
   int                      errors = 0;
   int                      timeouts = 0;
   logic [ADDR_W-1:0]       exp_src;           // transfer under check
   logic [ADDR_W-1:0]       exp_dst;
   int                      wr_idx;            // next expected write
   int                      rd_count = 0;      // all host reads seen
   int                      wr_count = 0;      // all memory writes seen
   int                      in_flight = 0;     // reads not yet written back
   int                      cred_min = 1;      // memory credit delay range
   int                      cred_max = 4;
   logic                    irq_seen;
   line_t                   mem [logic [ADDR_W-1:0]];  // memory bank contents
   logic [MMIO_DATA_W-1:0]  status;

   dma_copy_top u_dma_copy_top (
      .clk       (clk),
      .reset     (reset),
      .mmio_req  (mmio_req),
      .mmio_rsp  (mmio_rsp),
      .rd_req    (rd_req),
      .rd_rsp    (rd_rsp),
      .wr_req    (wr_req),
      .wr_credit (wr_credit),
      .irq       (irq)
   );

   always #5 clk = ~clk;  // 10 ns period

   always @(posedge clk)
      cycle <= cycle + 1;

   // host line content, unique per address
   function automatic line_t expected_line(input logic [ADDR_W-1:0] addr);
      expected_line = {addr ^ 32'hC0DE_5A5A, addr * 32'h9E37_79B1};
   endfunction

   // **************************************************
   // compare tasks
   // **************************************************
   task automatic check_line(input string name, input line_t got, input line_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                             input logic [ADDR_W-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_status(input logic [MMIO_DATA_W-1:0] got,
                               input logic [MMIO_DATA_W-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL status got %h expected %h at %0t", got, exp, $time);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // **************************************************
   // host read model and memory write model
   // **************************************************
   always @(posedge clk)
   begin : bus_models
      logic [ADDR_W-1:0] host_addr_q [$];
      int                host_due_q [$];
      int                cred_due_q [$];
      int                due;
      #1;
      if (reset)
      begin
         host_addr_q.delete();
         host_due_q.delete();
         cred_due_q.delete();
         rd_rsp    = '0;
         wr_credit = 1'b0;
      end
      else
      begin
         if (rd_req.valid)
         begin
            due = cycle + 1 + int'($urandom % 6);  // 1 to 6 cycles
            if (host_due_q.size() > 0 && due < host_due_q[$])
               due = host_due_q[$];               // keep answers in order
            host_addr_q.push_back(rd_req.address);
            host_due_q.push_back(due);
         end
         if (host_due_q.size() > 0 && host_due_q[0] <= cycle)
         begin
            rd_rsp = '{valid: 1'b1, data: expected_line(host_addr_q.pop_front())};
            void'(host_due_q.pop_front());
         end
         else
            rd_rsp = '{valid: 1'b0, data: '0};
         if (wr_req.valid)
         begin
            mem[wr_req.address] = wr_req.data;
            due = cycle + cred_min + int'($urandom % (cred_max - cred_min + 1));
            if (cred_due_q.size() > 0 && due < cred_due_q[$])
               due = cred_due_q[$];
            cred_due_q.push_back(due);
         end
         if (cred_due_q.size() > 0 && cred_due_q[0] <= cycle)
         begin
            void'(cred_due_q.pop_front());
            wr_credit = 1'b1;  // one credit per cycle at most
         end
         else
            wr_credit = 1'b0;
      end
   end

   // write stream compare and read credit watch
   always @(posedge clk)
   begin
      #1;
      if (!reset)
      begin
         if (wr_req.valid)
         begin
            check_addr("wr_req.address", wr_req.address, exp_dst + wr_idx);
            check_line("wr_req.data", wr_req.data, expected_line(exp_src + wr_idx));
            wr_idx++;
            wr_count++;
            in_flight--;  // written before new reads, slot already freed
         end
         if (rd_req.valid)
         begin
            rd_count++;
            in_flight++;
         end
         if (in_flight > RD_CREDITS)
         begin
            errors++;
            $display("more than %0d host reads in flight at %0t", RD_CREDITS, $time);
         end
         if (irq)
            irq_seen = 1'b1;
      end
   end

   // **************************************************
   // mmio access and wait tasks
   // **************************************************
   task automatic mmio_write(input logic [MMIO_ADDR_W-1:0] addr,
                             input logic [MMIO_DATA_W-1:0] data);
      @(posedge clk);
      #1;
      mmio_req = '{write: 1'b1, read: 1'b0, address: addr, writedata: data};
      @(posedge clk);
      #1;
      mmio_req = '0;
   endtask

   task automatic mmio_read(input logic [MMIO_ADDR_W-1:0] addr,
                            output logic [MMIO_DATA_W-1:0] data);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      mmio_req = '{write: 1'b0, read: 1'b1, address: addr, writedata: '0};
      @(posedge clk);
      #1;
      mmio_req = '0;
      while (!mmio_rsp.readdatavalid && n < 4)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      data = mmio_rsp.readdata;
      if (!mmio_rsp.readdatavalid)
      begin
         timeouts++;
         data = '0;
         $display("timeout waiting for the mmio read answer at %0t", $time);
      end
      else if (n != 0)
      begin
         errors++;
         $display("mmio read answered %0d cycles late at %0t", n, $time);
      end
   endtask

   task automatic wait_irq(input int limit);
      int n;
      n = 0;
      while (!irq && n < limit)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!irq)
      begin
         timeouts++;
         $display("timeout waiting for the interrupt at %0t", $time);
      end
   endtask

   task automatic wait_status_done(input int limit, output logic [MMIO_DATA_W-1:0] data);
      int n;
      n = 0;
      mmio_read(REG_STATUS, data);
      while (!data[1] && n < limit)
      begin
         mmio_read(REG_STATUS, data);
         n++;
      end
      if (!data[1])
      begin
         timeouts++;
         $display("timeout waiting for the done bit at %0t", $time);
      end
   endtask

   task automatic wait_writes(input int count, input int limit);
      int n;
      n = 0;
      while (wr_idx < count && n < limit)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (wr_idx < count)
      begin
         timeouts++;
         $display("timeout waiting for %0d memory writes, saw %0d", count, wr_idx);
      end
   endtask

   task automatic start_copy(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                             input int len, input logic irq_en);
      exp_src = src;
      exp_dst = dst;
      wr_idx  = 0;
      mem.delete();
      mmio_write(REG_SRC, MMIO_DATA_W'(src));
      mmio_write(REG_DST, MMIO_DATA_W'(dst));
      mmio_write(REG_LEN, MMIO_DATA_W'(len));
      mmio_write(REG_CTRL, {62'h0, irq_en, 1'b1});  // start with irq enable
   endtask

   task automatic verify_memory(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                                input int len);
      for (int i = 0; i < len; i++)
      begin
         if (!mem.exists(dst + i))
         begin
            errors++;
            $display("line %0d of the copy never reached memory", i);
         end
         else
            check_line("mem", mem[dst + i], expected_line(src + i));
      end
   endtask

   // **************************************************
   // test sequence
   // **************************************************
   initial
   begin
      int rd_before;
      int wr_before;
      void'($urandom(25228));
      reset    = 1'b1;
      mmio_req = '0;
      exp_src  = '0;
      exp_dst  = '0;
      wr_idx   = 0;
      irq_seen = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;

      // idle state after reset
      check_bit("irq", irq, 1'b0);
      check_bit("rd_req.valid", rd_req.valid, 1'b0);
      check_bit("wr_req.valid", wr_req.valid, 1'b0);
      check_bit("mmio_rsp.readdatavalid", mmio_rsp.readdatavalid, 1'b0);
      mmio_read(REG_STATUS, status);
      check_status(status, '0);

      // 12 lines, interrupt on
      start_copy(32'h0000_0100, 32'h0000_2000, 12, 1'b1);
      wait_irq(300);
      wait_writes(12, 50);
      mmio_read(REG_STATUS, status);
      check_status(status, {32'h0, 16'd12, 16'h0002});
      verify_memory(32'h0000_0100, 32'h0000_2000, 12);

      // 40 lines against slow write credits
      cred_min = 12;
      cred_max = 20;
      start_copy(32'h0000_5000, 32'h0000_9000, 40, 1'b1);
      wait_status_done(400, status);
      wait_writes(40, 50);
      check_status(status, {32'h0, 16'd40, 16'h0002});
      verify_memory(32'h0000_5000, 32'h0000_9000, 40);
      cred_min = 1;
      cred_max = 4;

      // zero length copy
      mmio_write(REG_STATUS, '0);
      check_bit("irq", irq, 1'b0);
      rd_before = rd_count;
      wr_before = wr_count;
      start_copy(32'h0000_0700, 32'h0000_0800, 0, 1'b1);
      wait_irq(20);
      repeat (10) @(posedge clk);
      #1;
      if (rd_count != rd_before || wr_count != wr_before)
      begin
         errors++;
         $display("zero-length copy issued host reads or memory writes");
      end
      mmio_read(REG_STATUS, status);
      check_status(status & 64'h3, 64'h2);  // progress field keeps the last copy

      // done cleared by a status write, then a copy without interrupt
      mmio_write(REG_STATUS, '0);
      check_bit("irq", irq, 1'b0);
      mmio_read(REG_STATUS, status);
      check_status(status & 64'h3, 64'h0);
      irq_seen = 1'b0;
      start_copy(32'h0000_0A00, 32'h0000_0B00, 8, 1'b0);
      wait_status_done(200, status);
      wait_writes(8, 50);
      check_status(status, {32'h0, 16'd8, 16'h0002});
      verify_memory(32'h0000_0A00, 32'h0000_0B00, 8);
      check_bit("irq_seen", irq_seen, 1'b0);

      $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
